/* Makefile */
VERILATOR ?= verilator
TOP       ?= fmaTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failures found

SIM_BIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

# a crashed simulation is logged as a failure too
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* flist.f */
rtl/fmaPkg.sv
rtl/fmaOperandIf.sv
rtl/fmaUnpack.sv
rtl/fmaMult.sv
rtl/fmaAlign.sv
rtl/fmaAdd.sv
rtl/fmaNormRound.sv
rtl/fmaPipe.sv
verif/fmaTb.sv

/* rtl/fmaAdd.sv */
// adds or subtracts the aligned addend and the product
// gives the magnitude, its exponent and the result sign
`timescale 1ns/1ps
`default_nettype none

module fmaAdd import fmaPkg::*; #(
  parameter int NE     = 5,
  parameter int NF     = 10,
  parameter int FMALEN = 3*NF+6
) (
  input  logic [2*NF+1:0]      Pm,
  input  logic signed [NE+1:0] Pe,
  input  logic [FMALEN-1:0]    Am,
  input  logic                 ASticky,
  input  logic                 KillProd,
  input  logic                 productSign,
  input  logic                 addendSign,
  input  logic                 ZZero,
  output logic [FMALEN-1:0]    Sm,
  output logic signed [NE+1:0] Se,
  output logic                 resultSign,
  output logic                 sumZero
);

  logic              effSub;
  logic [FMALEN-1:0] pAligned;
  logic              stickyA;
  logic              stickyP;
  logic [FMALEN-1:0] sumAdd;
  logic [FMALEN:0]   diffPos;
  logic [FMALEN-1:0] diffNeg;
  logic              negSum;
  logic              zeroTerms;

  assign effSub = productSign ^ addendSign;

  // product lined up under the addend, guard bits below
  assign pAligned = KillProd ? '0 : {(NF+2)'(0), Pm, GUARD_BITS'(0)};

  // sticky belongs to the addend unless the product was killed
  assign stickyA = ASticky & ~KillProd;
  assign stickyP = ASticky & KillProd;

  assign sumAdd = pAligned + Am;

  // P - A, the missing +1 is dropped while addend bits sit below
  assign diffPos = {1'b0, pAligned} + {1'b1, ~Am} + {{FMALEN{1'b0}}, ~stickyA};
  assign negSum  = effSub & diffPos[FMALEN];
  // A - P, a killed nonzero product takes one lsb off the addend
  assign diffNeg = Am + ~pAligned + {{(FMALEN-1){1'b0}}, ~stickyP};

  assign Sm = !effSub ? sumAdd : (negSum ? diffNeg : diffPos[FMALEN-1:0]);

  // exponent was already chosen in stage one
  assign Se = Pe;

  assign sumZero = ~|Sm;

  // product is zero whenever it was killed beside a zero addend
  assign zeroTerms = KillProd & ZZero;

  // exact zero is +0, only two negative zeros stay negative
  assign resultSign = sumZero ? (zeroTerms & productSign & addendSign)
                    : (negSum ? addendSign : productSign);

endmodule

`default_nettype wire

/* rtl/fmaAlign.sv */
// aligns the addend against the full-width product
// gives the shifted addend, its sticky bit and the product kill flag
`timescale 1ns/1ps
`default_nettype none

module fmaAlign import fmaPkg::*; #(
  parameter int NE     = 5,
  parameter int NF     = 10,
  parameter int FMALEN = 3*NF+6
) (
  fmaOperandIf.consumer     operands,
  output logic [FMALEN-1:0] Am,
  output logic              ASticky,
  output logic              KillProd
);

  localparam int BIAS = 2**(NE-1) - 1;

  logic signed [NE+1:0]   aCnt;
  logic [FMALEN+NF-1:0]   zmPre;
  logic [FMALEN+NF-1:0]   zmShifted;
  logic                   killZ;

  ////////////////////
  // shift count
  ////////////////////

  // taken from the raw exponents in parallel with the multiplier
  // aCnt of NF+1+GUARD_BITS puts the addend on the product's hidden bit
  assign aCnt = {2'b00, operands.Xe} + {2'b00, operands.Ye} - (NE+2)'(BIAS)
              + (NE+2)'(NF+1+GUARD_BITS) - {2'b00, operands.Ze};

  // addend starts at the very top with NF extra bits below for the sticky
  assign zmPre = {operands.Zm, (FMALEN-1)'(0)};

  // a negative count puts the product entirely below the addend lsb
  assign KillProd = (aCnt[NE+1] & ~operands.ZZero) | operands.XZero | operands.YZero;
  // addend falls past the guard bits
  assign killZ = aCnt > $signed((NE+2)'(3*NF+3+GUARD_BITS));

  ////////////////////
  // shifter
  ////////////////////

  always_comb begin
    if (KillProd) begin
      // addend parked on the product's hidden-bit position
      zmShifted = {(NF+3)'(0), operands.Zm, (2*NF+2)'(0)};
      ASticky   = ~(operands.XZero | operands.YZero);
    end else if (killZ) begin
      zmShifted = '0;
      ASticky   = ~operands.ZZero;
    end else begin
      zmShifted = zmPre >> aCnt;
      // bits that fell off the bottom
      ASticky   = |zmShifted[NF-1:0];
    end
  end

  assign Am = zmShifted[FMALEN+NF-1:NF];

  // below the kill threshold a nonzero addend always keeps its hidden bit inside Am
  always_comb begin
    if (!killZ && !operands.ZZero) begin
      assert (Am != '0);
    end
  end

endmodule

`default_nettype wire

/* rtl/fmaMult.sv */
// significand multiplier and product exponent
// combinational, part of stage one
`timescale 1ns/1ps
`default_nettype none

module fmaMult #(
  parameter int NE = 5,
  parameter int NF = 10
) (
  fmaOperandIf.consumer        operands,
  output logic [2*NF+1:0]      Pm,
  output logic signed [NE+1:0] Pe
);

  localparam int BIAS = 2**(NE-1) - 1;

  // full-width product, two integer bits in front of 2NF fraction bits
  assign Pm = operands.Xm * operands.Ym;

  // product exponent, may go negative on underflow
  // two spare bits keep the sign and the carry
  assign Pe = $signed({2'b00, operands.Xe}) + $signed({2'b00, operands.Ye})
            - $signed((NE+2)'(BIAS));

endmodule

`default_nettype wire

/* rtl/fmaNormRound.sv */
// normalizes the sum, rounds to nearest-even and packs the result
// combinational, end of stage two
`timescale 1ns/1ps
`default_nettype none

module fmaNormRound import fmaPkg::*; #(
  parameter int NE     = 5,
  parameter int NF     = 10,
  parameter int FMALEN = 3*NF+6
) (
  input  logic [FMALEN-1:0]    Sm,
  input  logic signed [NE+1:0] Se,
  input  logic                 resultSign,
  input  logic                 sumZero,
  input  logic                 ASticky,
  output logic [NE+NF:0]       result
);

  localparam int LZW = $clog2(FMALEN+1);
  localparam int EW  = NE + 4;
  // distance from the product hidden bit to the top of the sum
  localparam int EXP_OFFSET = FMALEN - 1 - 2*NF - GUARD_BITS;

  logic [LZW-1:0]       lzc;
  logic [FMALEN-1:0]    normSm;
  logic signed [EW-1:0] normExp;
  logic signed [EW-1:0] finalExp;
  logic [NF:0]          mant;
  logic                 guardBit;
  logic                 roundBit;
  logic                 stickyBit;
  logic                 roundUp;
  logic [NF+1:0]        rounded;
  logic [NF-1:0]        frac;
  logic                 underflow;

  ////////////////////
  // normalize
  ////////////////////

  // highest set bit wins, scanning upward
  always_comb begin
    lzc = LZW'(FMALEN);
    for (int i = 0; i < FMALEN; i++) begin
      if (Sm[i]) begin
        lzc = LZW'(FMALEN - 1 - i);
      end
    end
  end

  assign normSm  = Sm << lzc;
  assign normExp = EW'(Se) + EW'(EXP_OFFSET) - EW'(lzc);

  ////////////////////
  // round
  ////////////////////

  assign mant      = normSm[FMALEN-1 -: NF+1];
  assign guardBit  = normSm[FMALEN-NF-2];
  assign roundBit  = normSm[FMALEN-NF-3];
  assign stickyBit = (|normSm[FMALEN-NF-4:0]) | ASticky;

  // ties go to the even significand
  assign roundUp = guardBit & (roundBit | stickyBit | mant[0]);
  assign rounded = {1'b0, mant} + {{(NF+1){1'b0}}, roundUp};

  // carry out means 1.11..1 became 10.00..0
  assign finalExp  = normExp + EW'(rounded[NF+1]);
  assign frac      = rounded[NF+1] ? '0 : rounded[NF-1:0];
  assign underflow = finalExp <= 0;

  ////////////////////
  // pack
  ////////////////////

  assign result = (sumZero || underflow) ? {resultSign, {(NE+NF){1'b0}}}
                : {resultSign, finalExp[NE-1:0], frac};

  // overflow is outside the supported range
  always_comb begin
    if (|result[NE+NF-1:0]) begin
      assert (result[NE+NF-1:NF] != '1);
    end
  end

endmodule

`default_nettype wire

/* rtl/fmaOperandIf.sv */
// unpacked operand bundle from the unpacker to the multiplier and aligner
// producer drives every field, consumers only read
`timescale 1ns/1ps
`default_nettype none

interface fmaOperandIf import fmaPkg::*; #(
  parameter int NE = 5,
  parameter int NF = 10
) ();

  // signs after the opcode has been applied
  logic          productSign;
  logic          addendSign;
  // biased exponent fields
  logic [NE-1:0] Xe, Ye, Ze;
  // significands with hidden bit, zero when the operand is zero
  logic [NF:0]   Xm, Ym, Zm;
  logic          XZero, YZero, ZZero;
  fmaOpE         op;

  modport producer (
    output productSign, addendSign, Xe, Ye, Ze, Xm, Ym, Zm, XZero, YZero, ZZero, op
  );

  modport consumer (
    input productSign, addendSign, Xe, Ye, Ze, Xm, Ym, Zm, XZero, YZero, ZZero, op
  );

endinterface

`default_nettype wire

/* rtl/fmaPipe.sv */
// top level of the FMA unit with two register stages and valid/ready flow control
// stage one unpacks, multiplies and aligns
// stage two adds, normalizes and rounds
`timescale 1ns/1ps
`default_nettype none

module fmaPipe import fmaPkg::*; #(
  parameter int NE = 5,
  parameter int NF = 10
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           inValid,
  output logic           inReady,
  input  fmaOpE          op,
  input  logic [NE+NF:0] x,
  input  logic [NE+NF:0] y,
  input  logic [NE+NF:0] z,
  output logic           outValid,
  input  logic           outReady,
  output logic [NE+NF:0] result
);

  localparam int FMALEN = 3*NF + 6;

  fmaOperandIf #(.NE(NE), .NF(NF)) operands ();

  logic [2*NF+1:0]      pm;
  logic signed [NE+1:0] pe;
  logic [FMALEN-1:0]    am;
  logic                 aSticky;
  logic                 killProd;
  // stage one register
  logic                 s1Valid;
  logic [2*NF+1:0]      s1Pm;
  logic signed [NE+1:0] s1Exp;
  logic [FMALEN-1:0]    s1Am;
  logic                 s1ASticky, s1KillProd, s1PSign, s1ASign, s1ZZero;
  // stage two outputs
  logic [FMALEN-1:0]    sm;
  logic signed [NE+1:0] se;
  logic                 resultSign, sumZero;
  logic [NE+NF:0]       rounded;
  logic                 s2Ready;

  ////////////////////
  // stage one
  ////////////////////

  fmaUnpack #(.NE(NE), .NF(NF)) unpack (.op(op), .x(x), .y(y), .z(z), .operands(operands));

  fmaMult #(.NE(NE), .NF(NF)) mult (.operands(operands), .Pm(pm), .Pe(pe));

  fmaAlign #(.NE(NE), .NF(NF), .FMALEN(FMALEN)) align (
    .operands(operands), .Am(am), .ASticky(aSticky), .KillProd(killProd)
  );

  // each register loads when empty or when the stage after it drains
  assign s2Ready = ~outValid | outReady;
  assign inReady = ~s1Valid | s2Ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid <= 1'b0;
    end else if (inReady) begin
      s1Valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inReady && inValid) begin
      s1Pm       <= pm;
      // a killed product leaves the addend on the product position
      s1Exp      <= killProd ? $signed({2'b00, operands.Ze}) : pe;
      s1Am       <= am;
      s1ASticky  <= aSticky;
      s1KillProd <= killProd;
      s1PSign    <= operands.productSign;
      s1ASign    <= operands.addendSign;
      s1ZZero    <= operands.ZZero;
    end
  end

  ////////////////////
  // stage two
  ////////////////////

  fmaAdd #(.NE(NE), .NF(NF), .FMALEN(FMALEN)) add (
    .Pm(s1Pm), .Pe(s1Exp), .Am(s1Am), .ASticky(s1ASticky), .KillProd(s1KillProd),
    .productSign(s1PSign), .addendSign(s1ASign), .ZZero(s1ZZero),
    .Sm(sm), .Se(se), .resultSign(resultSign), .sumZero(sumZero)
  );

  fmaNormRound #(.NE(NE), .NF(NF), .FMALEN(FMALEN)) normRound (
    .Sm(sm), .Se(se), .resultSign(resultSign), .sumZero(sumZero),
    .ASticky(s1ASticky), .result(rounded)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (s2Ready) begin
      outValid <= s1Valid;
    end
  end

  // result register
  always_ff @(posedge clk) begin
    if (s2Ready && s1Valid) begin
      result <= rounded;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // a stalled result must hold until taken
  assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> $stable(result));

endmodule

`default_nettype wire

/* rtl/fmaPkg.sv */
// shared opcode type and fixed datapath constants for the FMA unit
// imported by the datapath modules and the testbench
`default_nettype none

package fmaPkg;

  ////////////////////
  // operations
  ////////////////////

  // bit 0 negates the addend and bit 1 negates the product
  typedef enum logic [1:0] {
    FMADD  = 2'b00,
    FMSUB  = 2'b01,
    FNMADD = 2'b10,
    FNMSUB = 2'b11
  } fmaOpE;

  ////////////////////
  // datapath constants
  ////////////////////

  // extra low bits kept below the product lsb for rounding
  localparam int GUARD_BITS = 2;

endpackage

`default_nettype wire

/* rtl/fmaUnpack.sv */
// splits the three inputs into fields and applies the opcode's signs
// combinational, first part of stage one
`timescale 1ns/1ps
`default_nettype none

module fmaUnpack import fmaPkg::*; #(
  parameter int NE = 5,
  parameter int NF = 10
) (
  input  fmaOpE           op,
  input  logic [NE+NF:0]  x,
  input  logic [NE+NF:0]  y,
  input  logic [NE+NF:0]  z,
  fmaOperandIf.producer   operands
);

  logic negProduct;
  logic negAddend;

  // exponent fields
  assign operands.Xe = x[NE+NF-1:NF];
  assign operands.Ye = y[NE+NF-1:NF];
  assign operands.Ze = z[NE+NF-1:NF];

  // zero exponent means zero, subnormals are flushed here
  assign operands.XZero = ~|x[NE+NF-1:NF];
  assign operands.YZero = ~|y[NE+NF-1:NF];
  assign operands.ZZero = ~|z[NE+NF-1:NF];

  // hidden bit in front, whole significand cleared for a zero
  assign operands.Xm = operands.XZero ? '0 : {1'b1, x[NF-1:0]};
  assign operands.Ym = operands.YZero ? '0 : {1'b1, y[NF-1:0]};
  assign operands.Zm = operands.ZZero ? '0 : {1'b1, z[NF-1:0]};

  // opcode negation rules
  assign negProduct = (op == FNMADD) || (op == FNMSUB);
  assign negAddend  = (op == FMSUB) || (op == FNMSUB);

  assign operands.productSign = x[NE+NF] ^ y[NE+NF] ^ negProduct;
  assign operands.addendSign  = z[NE+NF] ^ negAddend;
  assign operands.op          = op;

endmodule

`default_nettype wire

/* verif/fmaStimulus.txt */
// opcode x y z expected, all hex, one vector per line
// opcode 0 fmadd, 1 fmsub, 2 fnmadd, 3 fnmsub
0 4000 4200 3C00 4700
0 3E00 4100 3400 4400
0 4200 4500 C000 4A80
1 4000 4200 3C00 4500
2 4000 4200 3C00 C500
3 4000 4200 3C00 C700
0 3000 3000 6801 6801
1 3000 3000 6800 E800
1 6600 4800 1400 7200
1 4C01 4C01 5C02 0C00
1 3FFF 3FFF 4400 9C00
0 0000 4200 3E00 3E00
0 4000 0000 BE00 BE00
0 3C01 3C01 0000 3C02
2 4000 4200 4600 0000
0 8000 0000 8000 8000
0 3C00 3C00 1000 3C00
0 3C01 3C00 1000 3C02
1 3C00 4000 1000 4000
0 3C00 3C00 1001 3C01
0 3C01 3E00 0000 3E02
2 3C01 3E00 0000 BE02

/* verif/fmaTb.sv */
// testbench for the pipelined FMA unit that reads vectors from the stimulus file
// drives them with random gaps, stalls the output at random and checks results in order
`timescale 1ns/1ps
`default_nettype none

module fmaTb import fmaPkg::*; ();

  localparam string STIM_FILE = "verif/fmaStimulus.txt";
  localparam int    W         = 16;

  logic         clk;
  logic         rst;
  logic         inValid;
  logic         inReady;
  fmaOpE        op;
  logic [W-1:0] x;
  logic [W-1:0] y;
  logic [W-1:0] z;
  logic         outValid;
  logic         outReady;
  logic [W-1:0] result;

  // vectors in file order
  logic [1:0]   opQ[$];
  logic [W-1:0] xQ[$];
  logic [W-1:0] yQ[$];
  logic [W-1:0] zQ[$];
  logic [W-1:0] expQ[$];

  int nVec    = 0;
  int rxCount = 0;
  int errors  = 0;
  bit loaded  = 1'b0;

  fmaPipe DUT (
    .clk(clk), .rst(rst),
    .inValid(inValid), .inReady(inReady), .op(op), .x(x), .y(y), .z(z),
    .outValid(outValid), .outReady(outReady), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // vector file
  ////////////////////

  task automatic readVectors();
    int           fd;
    int           cnt;
    string        lineBuf;
    logic [W-1:0] fOp;
    logic [W-1:0] fX;
    logic [W-1:0] fY;
    logic [W-1:0] fZ;
    logic [W-1:0] fRes;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("error: cannot open %s", STIM_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(lineBuf, fd) != 0) begin
          // comment and blank lines give fewer than five fields
          cnt = $sscanf(lineBuf, "%h %h %h %h %h", fOp, fX, fY, fZ, fRes);
          if (cnt == 5) begin
            opQ.push_back(fOp[1:0]);
            xQ.push_back(fX);
            yQ.push_back(fY);
            zQ.push_back(fZ);
            expQ.push_back(fRes);
          end
        end
      end
      $fclose(fd);
    end
    nVec = expQ.size();
    if (nVec == 0) begin
      $display("error: no test vectors were read");
      errors++;
    end
  endtask

  ////////////////////
  // input side
  ////////////////////

  // holds the vector until the handshake, which lands on the next rising edge
  task automatic sendVector(input int idx);
    @(posedge clk);
    inValid <= 1'b1;
    op      <= fmaOpE'(opQ[idx]);
    x       <= xQ[idx];
    y       <= yQ[idx];
    z       <= zQ[idx];
    do begin
      @(negedge clk);
    end while (!inReady);
  endtask

  initial begin
    int gap;
    void'($urandom(32'h6fc4_b4da));
    rst      = 1'b1;
    inValid  = 1'b0;
    op       = FMADD;
    x        = '0;
    y        = '0;
    z        = '0;
    outReady = 1'b0;
    readVectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < nVec; i++) begin
      // occasional idle cycles between vectors
      gap = (($urandom % 4) == 0) ? ($urandom % 3) + 1 : 0;
      repeat (gap) begin
        @(posedge clk);
        inValid <= 1'b0;
      end
      sendVector(i);
    end
    @(posedge clk);
    inValid <= 1'b0;
    wait (rxCount == nVec);
    // a few more cycles so a duplicate result would still show up
    repeat (10) @(posedge clk);
    $display("%0d errors, %0d of %0d vectors checked", errors, rxCount, nVec);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  ////////////////////
  // output side
  ////////////////////

  // random back-pressure with ready about three cycles in four
  always @(posedge clk) begin
    outReady <= rst ? 1'b0 : (($urandom % 4) != 0);
  end

  // sampled mid-cycle before the transfer on the next rising edge
  always @(negedge clk) begin
    if (!rst && outValid && outReady) begin
      if (rxCount >= nVec) begin
        $display("error: unexpected extra result %h at %0t", result, $time);
        errors++;
      end else begin
        if (result != expQ[rxCount]) begin
          $display("mismatch at %0t: result expected %h, got %h (vector %0d)",
                   $time, expQ[rxCount], result, rxCount);
          errors++;
        end
        rxCount++;
      end
    end
  end

  // watchdog sized from the number of vectors
  initial begin
    wait (loaded);
    repeat (40 * nVec + 100) @(posedge clk);
    $display("timeout: only %0d of %0d results arrived in time", rxCount, nVec);
    $display("%0d errors, %0d of %0d vectors checked", errors + 1, rxCount, nVec);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
